//--- sources.f
uart_pkg.sv
uart_rx.sv
uart_tx.sv
byte_fifo.sv
uart_echo.sv
uart_echo_checker.sv
uart_echo_tb.sv

//--- Makefile
VERILATOR = verilator
TOP       = uart_echo_tb
FILELIST  = sources.f
VFLAGS    = --binary --timing --top-module $(TOP)
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- uart_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_echo_tb import uart_pkg::*; ();

   localparam int CLK_NS = 4;
   // frames over all bursts
   localparam int TOTAL_FRAMES = 6 + 16 + 5 + (FIFO_DEPTH + 3);
   localparam int WATCHDOG_NS = (TOTAL_FRAMES * 12 + 600) * CLK_PER_BIT * CLK_NS;
   // longest echo backlog is a full fifo after hold is released
   localparam int ECHO_WAIT_CLKS = (FIFO_DEPTH + 2) * 12 * CLK_PER_BIT;

   logic clk;
   logic rstn;
   logic rxd;
   logic hold;
   logic txd;
   logic frame_err;
   logic overrun;

   logic [31:0] lcg_state = 32'hb51560a7;
   byte_t       frame_data [$];
   bit          frame_bad [$];
   byte_t       exp_bytes [$];
   int          exp_ferr;
   int          exp_ovr;

   uart_echo dut (
      .clk       (clk),
      .rstn      (rstn),
      .rxd       (rxd),
      .hold      (hold),
      .txd       (txd),
      .frame_err (frame_err),
      .overrun   (overrun)
   );

   uart_echo_checker chk (
      .clk       (clk),
      .rstn      (rstn),
      .txd       (txd),
      .frame_err (frame_err),
      .overrun   (overrun)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // echo path model: bad frames only flag, hold keeps the first FIFO_DEPTH bytes
   function automatic void model_echo(input bit held);
      int kept;
      exp_bytes.delete();
      exp_ferr = 0;
      exp_ovr = 0;
      kept = 0;
      for (int i = 0; i < frame_data.size(); i++) begin
         if (frame_bad[i]) begin
            exp_ferr++;
         end else if (held && kept == FIFO_DEPTH) begin
            exp_ovr++;
         end else begin
            exp_bytes.push_back(frame_data[i]);
            kept++;
         end
      end
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // rxd driver, entered and left 1 ns after a rising edge
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   task automatic drive_bit(input logic v);
      rxd = v;
      repeat (CLK_PER_BIT) @(posedge clk);
      #1;
   endtask

   task automatic send_frame(input byte_t d, input bit bad_stop);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) begin
         drive_bit(d[i]);
      end
      drive_bit(!bad_stop);
   endtask

   task automatic idle_bits(input int n);
      rxd = 1'b1;
      repeat (n * CLK_PER_BIT) @(posedge clk);
      #1;
   endtask

   task automatic run_burst(input string name, input int n, input bit gaps,
                            input int bad_idx, input bit held);
      int seen;
      int waited;
      frame_data.delete();
      frame_bad.delete();
      for (int i = 0; i < n; i++) begin
         frame_data.push_back(byte_t'(lcg_next() >> 8));
         frame_bad.push_back(i == bad_idx);
      end
      model_echo(held);
      foreach (exp_bytes[i]) begin
         chk.expect_byte(exp_bytes[i]);
      end
      seen = chk.bytes_seen;
      hold = held;
      for (int i = 0; i < n; i++) begin
         send_frame(frame_data[i], frame_bad[i]);
         // a gap also lets the false start after a low stop bit die out
         if (gaps) begin
            idle_bits(2 + int'(lcg_next() % 10));
         end
      end
      if (held) begin
         if (chk.bytes_seen != seen || txd !== 1'b1) begin
            chk.report_failure("txd was active while hold was high");
         end
         hold = 1'b0;
      end
      waited = 0;
      while (chk.pending != 0 && waited < ECHO_WAIT_CLKS) begin
         @(posedge clk);
         #1;
         waited++;
      end
      // quiet line, any extra byte shows up here
      idle_bits(20);
      chk.end_test(name, exp_ferr, exp_ovr);
   endtask

   initial begin
      rstn = 1'b0;
      rxd = 1'b1;
      hold = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      run_burst("idle line after reset", 0, 1'b0, -1, 1'b0);
      run_burst("single bytes with gaps", 6, 1'b1, -1, 1'b0);
      run_burst("back to back frames", 16, 1'b0, -1, 1'b0);
      run_burst("low stop bit", 5, 1'b1, 2, 1'b0);
      run_burst("hold and overrun", FIFO_DEPTH + 3, 1'b0, -1, 1'b1);
      $display("summary: %0d bytes on txd, %0d frame_err, %0d overrun, %0d errors",
               chk.bytes_seen, chk.ferr_cnt, chk.ovr_cnt, chk.errors);
      if (chk.errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- uart_echo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_echo_checker import uart_pkg::*; (
   input logic clk,
   input logic rstn,
   input logic txd,
   input logic frame_err,
   input logic overrun
);

   byte_t exp_q [$];
   int    pending = 0;
   int    errors = 0;
   int    bytes_seen = 0;
   int    ferr_cnt = 0;
   int    ovr_cnt = 0;
   int    ferr_base = 0;
   int    ovr_base = 0;
   int    err_base = 0;

   function automatic void expect_byte(input byte_t b);
      exp_q.push_back(b);
      pending = exp_q.size();
   endfunction

   function automatic void report_failure(input string msg);
      errors++;
      $display("%0t ns: %s", $time, msg);
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // txd decoder, samples near bit centres on the falling clock
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      byte_t got;
      byte_t want;
      wait (rstn === 1'b1);
      forever begin
         @(negedge clk);
         if (txd === 1'b0) begin
            // start bit seen half a clock after its edge
            repeat (CLK_PER_HALF_BIT - 1) @(negedge clk);
            if (txd !== 1'b0) begin
               report_failure("txd start bit ended before its centre");
            end
            for (int i = 0; i < 8; i++) begin
               repeat (CLK_PER_BIT) @(negedge clk);
               got[i] = txd;
            end
            repeat (CLK_PER_BIT) @(negedge clk);
            if (txd !== 1'b1) begin
               report_failure("txd stop bit was low");
            end
            bytes_seen++;
            if (exp_q.size() == 0) begin
               report_failure($sformatf("unexpected byte 8'h%02h on txd", got));
            end else begin
               want = exp_q.pop_front();
               pending = exp_q.size();
               if (got !== want) begin
                  errors++;
                  $display("ERROR at %0t ns: txd_byte expected 8'h%02h actual 8'h%02h",
                           $time, want, got);
               end
            end
         end else if (txd !== 1'b1) begin
            report_failure("txd was neither high nor low on the idle line");
         end
      end
   end

   // status pulses are one cycle wide
   always @(negedge clk) begin
      if (rstn) begin
         if (frame_err) begin
            ferr_cnt++;
         end
         if (overrun) begin
            ovr_cnt++;
         end
      end
   end

   function automatic void end_test(input string name, input int want_ferr,
                                    input int want_ovr);
      if (ferr_cnt - ferr_base != want_ferr) begin
         errors++;
         $display("ERROR at %0t ns: frame_err count expected %0d actual %0d",
                  $time, want_ferr, ferr_cnt - ferr_base);
      end
      if (ovr_cnt - ovr_base != want_ovr) begin
         errors++;
         $display("ERROR at %0t ns: overrun count expected %0d actual %0d",
                  $time, want_ovr, ovr_cnt - ovr_base);
      end
      if (pending != 0) begin
         report_failure($sformatf("%0d expected bytes never appeared on txd", pending));
         exp_q.delete();
         pending = 0;
      end
      $display("test %s: %s, %0d errors", name, (errors == err_base) ? "ok" : "failed",
               errors - err_base);
      ferr_base = ferr_cnt;
      ovr_base = ovr_cnt;
      err_base = errors;
   endfunction

endmodule

`default_nettype wire

//--- uart_echo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_echo import uart_pkg::*; (
   input  logic clk,
   input  logic rstn,
   input  logic rxd,
   input  logic hold,
   output logic txd,
   output logic frame_err,
   output logic overrun
);

   rx_event_t rx_ev;
   byte_t     fifo_head;
   logic      fifo_full;
   logic      fifo_empty;
   logic      tx_start;
   logic      tx_busy;
   logic      start_q;

   uart_rx u_rx (
      .clk   (clk),
      .rstn  (rstn),
      .rxd   (rxd),
      .rx_ev (rx_ev)
   );

   byte_fifo u_fifo (
      .clk     (clk),
      .rstn    (rstn),
      .push    (rx_ev.valid),
      .wr_data (rx_ev.data),
      .pop     (tx_start),
      .rd_data (fifo_head),
      .full    (fifo_full),
      .empty   (fifo_empty)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // transmit issue
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // tx_busy lags a start by one cycle, so block back to back starts
   always_ff @(posedge clk) begin
      if (!rstn) begin
         start_q <= 1'b0;
      end else begin
         start_q <= tx_start;
      end
   end

   // start and pop go together
   assign tx_start = !fifo_empty && !hold && !tx_busy && !start_q;

   uart_tx u_tx (
      .clk      (clk),
      .rstn     (rstn),
      .tx_start (tx_start),
      .sdata    (fifo_head),
      .tx_busy  (tx_busy),
      .txd      (txd)
   );

   // status pulses
   assign frame_err = rx_ev.frame_err;
   assign overrun = rx_ev.valid && fifo_full;

endmodule

`default_nettype wire

//--- byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo import uart_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  push,
   input  byte_t wr_data,
   input  logic  pop,
   output byte_t rd_data,
   output logic  full,
   output logic  empty
);

   byte_t     mem [FIFO_DEPTH];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_ptr_t wr_ptr_nxt;
   fifo_ptr_t rd_ptr_nxt;
   logic      do_push;
   logic      do_pop;

   // push on full and pop on empty are dropped
   assign do_push = push && !full;
   assign do_pop = pop && !empty;

   assign wr_ptr_nxt = wr_ptr + fifo_ptr_t'(do_push);
   assign rd_ptr_nxt = rd_ptr + fifo_ptr_t'(do_pop);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // pointers and flags
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         full <= 1'b0;
         empty <= 1'b1;
      end else begin
         wr_ptr <= wr_ptr_nxt;
         rd_ptr <= rd_ptr_nxt;
         empty <= (wr_ptr_nxt == rd_ptr_nxt);
         // same slot, different lap
         full <= (wr_ptr_nxt[FIFO_AW] != rd_ptr_nxt[FIFO_AW]) &&
                 (wr_ptr_nxt[FIFO_AW-1:0] == rd_ptr_nxt[FIFO_AW-1:0]);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // storage
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
      end
   end

   // head byte, valid while not empty
   assign rd_data = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx import uart_pkg::*; (
   input  logic  clk,
   input  logic  rstn,
   input  logic  tx_start,
   input  byte_t sdata,
   output logic  tx_busy,
   output logic  txd
);

   tx_state_t state;
   baudcnt_t  counter;
   bitcnt_t   bit_idx;
   byte_t     txbuf;
   logic      accept;
   logic      next_ev;
   logic      stop_ev;

   assign accept = (state == tx_idle) && tx_start;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // baud events
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign next_ev = (counter == baudcnt_t'(CLK_PER_BIT - 1));
   assign stop_ev = (counter == baudcnt_t'(CLK_STOP_BIT - 1));

   // free running, realigned on every accepted start
   always_ff @(posedge clk) begin
      if (!rstn) begin
         counter <= '0;
      end else if (accept || next_ev) begin
         counter <= '0;
      end else begin
         counter <= counter + baudcnt_t'(1);
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // shift state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= tx_idle;
         bit_idx <= '0;
         txd <= 1'b1;
         tx_busy <= 1'b0;
      end else begin
         unique case (state)
            tx_idle: begin
               if (tx_start) begin
                  txd <= 1'b0;
                  state <= tx_start_bit;
               end
            end
            tx_start_bit: begin
               // busy follows the accepting edge by one clock
               tx_busy <= 1'b1;
               if (next_ev) begin
                  txd <= txbuf[0];
                  bit_idx <= '0;
                  state <= tx_data;
               end
            end
            tx_data: begin
               if (next_ev) begin
                  if (bit_idx == bitcnt_t'(7)) begin
                     txd <= 1'b1;
                     state <= tx_stop_bit;
                  end else begin
                     txd <= txbuf[0];
                     bit_idx <= bit_idx + bitcnt_t'(1);
                  end
               end
            end
            tx_stop_bit: begin
               // short stop, line stays high through idle
               if (stop_ev) begin
                  tx_busy <= 1'b0;
                  state <= tx_idle;
               end
            end
            default: begin
               state <= tx_idle;
            end
         endcase
      end
   end

   // byte buffer, bit 0 always holds the next bit to send
   always_ff @(posedge clk) begin
      if (accept) begin
         txbuf <= sdata;
      end else if (next_ev && (state == tx_start_bit || state == tx_data)) begin
         txbuf <= txbuf >> 1;
      end
   end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import uart_pkg::*; (
   input  logic      clk,
   input  logic      rstn,
   input  logic      rxd,
   output rx_event_t rx_ev
);

   logic      rxd_meta;
   logic      rxd_s;
   rx_state_t state;
   baudcnt_t  counter;
   bitcnt_t   bit_idx;
   byte_t     shreg;
   logic      half_ev;
   logic      bit_ev;
   logic      ev_valid;
   logic      ev_ferr;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // input synchroniser
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // idle line is high
   always_ff @(posedge clk) begin
      if (!rstn) begin
         rxd_meta <= 1'b1;
         rxd_s <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_s <= rxd_meta;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // frame state machine
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign half_ev = (counter == baudcnt_t'(CLK_PER_HALF_BIT - 1));
   assign bit_ev = (counter == baudcnt_t'(CLK_PER_BIT - 1));

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= rx_idle;
         counter <= '0;
         bit_idx <= '0;
         ev_valid <= 1'b0;
         ev_ferr <= 1'b0;
      end else begin
         ev_valid <= 1'b0;
         ev_ferr <= 1'b0;
         counter <= counter + baudcnt_t'(1);

         unique case (state)
            rx_idle: begin
               counter <= '0;
               if (!rxd_s) begin
                  state <= rx_start_bit;
               end
            end
            rx_start_bit: begin
               // recheck at the start bit centre, a short glitch goes back to idle
               if (half_ev) begin
                  counter <= '0;
                  bit_idx <= '0;
                  if (rxd_s) begin
                     state <= rx_idle;
                  end else begin
                     state <= rx_data;
                  end
               end
            end
            rx_data: begin
               if (bit_ev) begin
                  counter <= '0;
                  if (bit_idx == bitcnt_t'(7)) begin
                     state <= rx_stop_bit;
                  end else begin
                     bit_idx <= bit_idx + bitcnt_t'(1);
                  end
               end
            end
            rx_stop_bit: begin
               // report at stop centre, ready for the next start edge
               if (bit_ev) begin
                  ev_valid <= rxd_s;
                  ev_ferr <= !rxd_s;
                  state <= rx_idle;
               end
            end
            default: begin
               state <= rx_idle;
            end
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge clk) begin
      if (state == rx_data && bit_ev) begin
         shreg <= {rxd_s, shreg[7:1]};
      end
   end

   // shreg stays put from the last data bit until the next frame
   assign rx_ev = '{valid: ev_valid, frame_err: ev_ferr, data: shreg};

endmodule

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // bit timing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // short bit time for simulation
   localparam int CLK_PER_HALF_BIT = 4;
   localparam int CLK_PER_BIT = CLK_PER_HALF_BIT * 2;
   // tx stop bit is cut to nine tenths of a bit
   localparam int CLK_STOP_BIT = (CLK_PER_BIT * 9) / 10;

   // byte fifo
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AW = 3;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // types
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [7:0] byte_t;
   typedef logic [2:0] bitcnt_t;
   typedef logic [15:0] baudcnt_t;
   // extra msb tells full from empty
   typedef logic [FIFO_AW:0] fifo_ptr_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start_bit,
      tx_data,
      tx_stop_bit
   } tx_state_t;

   typedef enum logic [1:0] {
      rx_idle,
      rx_start_bit,
      rx_data,
      rx_stop_bit
   } rx_state_t;

   // one event per received frame
   typedef struct packed {
      logic  valid;
      logic  frame_err;
      byte_t data;
   } rx_event_t;

endpackage

`default_nettype wire
